// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 64;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes and function codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;

    localparam logic [31:0] inst_nop = 32'h0000_0013; // addi x0, x0, 0.

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [6:0] f7_alt = 7'b0100000; // sub and sra.

    localparam logic [2:0] ld_b  = 3'b000;
    localparam logic [2:0] ld_h  = 3'b001;
    localparam logic [2:0] ld_w  = 3'b010;
    localparam logic [2:0] ld_d  = 3'b011;
    localparam logic [2:0] ld_bu = 3'b100;
    localparam logic [2:0] ld_hu = 3'b101;
    localparam logic [2:0] ld_wu = 3'b110;

    // hazard state machine
    localparam logic [1:0] hz_run       = 2'd0;
    localparam logic [1:0] hz_interlock = 2'd1;
    localparam logic [1:0] hz_hold      = 2'd2;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_form;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_form;
    } rv_inst_t;

endpackage

`default_nettype wire

// ==== pc_counter.sv ====
`default_nettype none

module pc_counter (
    input  wire                   CLK,
    input  wire                   reset,
    input  wire                   hold,
    input  wire                   bubble,
    input  wire [31:0]            inst,
    output logic [63:0]           inst_addr,
    output rv_core_pkg::rv_inst_t fd_inst
);
    import rv_core_pkg::*;

    logic [xlen-1:0] pc;

    assign inst_addr = pc; // fetch address, word read comes back this cycle.

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            pc      <= '0;
            fd_inst <= inst_nop;
        end else if (!hold) begin
            if (bubble) begin
                fd_inst <= inst_nop; // pc stays put.
            end else begin
                pc      <= pc + 64'd4;
                fd_inst <= inst;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hazard_control.sv ====
`default_nettype none

module hazard_control (
    input  wire       CLK,
    input  wire       reset,
    input  wire       stall,
    input  wire       fd_uses_rs1,
    input  wire       fd_uses_rs2,
    input  wire [4:0] fd_rs1,
    input  wire [4:0] fd_rs2,
    input  wire       dx_is_load,
    input  wire [4:0] dx_rd,
    output logic      hold,
    output logic      bubble
);
    import rv_core_pkg::*;

    logic [1:0] state;
    logic [1:0] state_next;
    logic       load_use;

    // waiting instruction reads the register a load in execute is about to fill.
    assign load_use = dx_is_load && (dx_rd != 5'd0) &&
                      ((fd_uses_rs1 && fd_rs1 == dx_rd) ||
                       (fd_uses_rs2 && fd_rs2 == dx_rd));

    always_comb begin
        state_next = hz_run;
        hold       = 1'b0;
        case (state)
            hz_run: begin
                if (stall) begin
                    state_next = hz_hold;
                    hold       = 1'b1;
                end else if (load_use) begin
                    state_next = hz_interlock;
                    hold       = 1'b1;
                end
            end
            hz_interlock, hz_hold: begin
                if (stall) begin
                    state_next = hz_hold;
                    hold       = 1'b1;
                end
            end
            default: state_next = hz_run;
        endcase
    end

    assign bubble = hold; // decode inserts a nop whenever fetch is frozen.

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            state <= hz_run;
        end else begin
            state <= state_next;
        end
    end

    a_interlock_single : assert property (@(posedge CLK) disable iff (!reset)
        state == hz_interlock |-> !load_use)
        else $error("load-use hazard still present after the interlock bubble");

endmodule

`default_nettype wire

// ==== inst_decode.sv ====
`default_nettype none

module inst_decode (
    input  wire                        CLK,
    input  wire                        reset,
    input  wire rv_core_pkg::rv_inst_t fd_inst,
    input  wire                        bubble,
    input  wire                        wb_en,
    input  wire [4:0]                  wb_rd,
    input  wire [63:0]                 wb_value,
    output logic                       fd_uses_rs1,
    output logic                       fd_uses_rs2,
    output logic [4:0]                 fd_rs1,
    output logic [4:0]                 fd_rs2,
    output logic                       dx_valid,
    output logic [4:0]                 dx_rd,
    output logic [4:0]                 dx_rs1,
    output logic [4:0]                 dx_rs2,
    output logic [2:0]                 dx_funct3,
    output logic                       dx_funct7_alt,
    output logic [63:0]                dx_op1,
    output logic [63:0]                dx_op2,
    output logic                       dx_imm_flag,
    output logic                       dx_is_load,
    output logic                       dx_write_back
);
    import rv_core_pkg::*;

    logic [xlen-1:0] regs [32];
    rv_inst_t        cur;
    logic [6:0]      opcode;
    logic            is_op;
    logic            is_op_imm;
    logic            is_load;
    logic            known;
    logic            alt;
    logic [xlen-1:0] imm_sext;

    // register read with same-cycle writeback bypass.
    function automatic logic [xlen-1:0] read_reg(input logic [4:0] idx);
        if (wb_en && idx == wb_rd && idx != 5'd0) begin
            return wb_value;
        end
        return regs[idx];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hazard view of the waiting instruction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign fd_rs1      = fd_inst.r_form.rs1;
    assign fd_rs2      = fd_inst.r_form.rs2;
    assign fd_uses_rs1 = fd_inst.r_form.opcode inside {opc_op, opc_op_imm, opc_load};
    assign fd_uses_rs2 = fd_inst.r_form.opcode == opc_op;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cur       = bubble ? rv_inst_t'(inst_nop) : fd_inst;
    assign opcode    = cur.r_form.opcode;
    assign is_op     = opcode == opc_op;
    assign is_op_imm = opcode == opc_op_imm;
    assign is_load   = opcode == opc_load;
    assign known     = is_op || is_op_imm || is_load;
    assign imm_sext  = {{(xlen-12){cur.i_form.imm12[11]}}, cur.i_form.imm12};

    always_comb begin
        if (is_op) begin
            alt = cur.r_form.funct7 == f7_alt;
        end else if (is_op_imm && cur.i_form.funct3 == f3_srl) begin
            alt = cur.i_form.imm12[11:6] == f7_alt[6:1]; // srai, shamt[5] sits in bit 25.
        end else begin
            alt = 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_value;
        end
    end

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            dx_valid      <= 1'b0;
            dx_imm_flag   <= 1'b0;
            dx_is_load    <= 1'b0;
            dx_write_back <= 1'b0;
        end else begin
            dx_valid      <= known;
            dx_imm_flag   <= is_op_imm || is_load;
            dx_is_load    <= is_load;
            dx_write_back <= known && cur.r_form.rd != 5'd0; // x0 writes never retire.
        end
    end

    always_ff @(posedge CLK) begin
        dx_rd         <= cur.r_form.rd;
        dx_rs1        <= cur.i_form.rs1;
        dx_rs2        <= is_op ? cur.r_form.rs2 : 5'd0;
        dx_funct3     <= cur.i_form.funct3;
        dx_funct7_alt <= alt;
        dx_op1        <= read_reg(cur.i_form.rs1);
        dx_op2        <= is_op ? read_reg(cur.r_form.rs2) : imm_sext;
    end

    a_x0_zero : assert property (@(posedge CLK) disable iff (!reset)
        regs[0] == '0)
        else $error("register x0 holds a nonzero value");

endmodule

`default_nettype wire

// ==== alu_execute.sv ====
`default_nettype none

module alu_execute (
    input  wire        CLK,
    input  wire        reset,
    input  wire        dx_valid,
    input  wire [4:0]  dx_rd,
    input  wire [4:0]  dx_rs1,
    input  wire [4:0]  dx_rs2,
    input  wire [2:0]  dx_funct3,
    input  wire        dx_funct7_alt,
    input  wire [63:0] dx_op1,
    input  wire [63:0] dx_op2,
    input  wire        dx_imm_flag,
    input  wire        dx_is_load,
    input  wire        dx_write_back,
    input  wire        wb_en,
    input  wire [4:0]  wb_rd,
    input  wire [63:0] wb_value,
    output logic       xw_valid,
    output logic [4:0] xw_rd,
    output logic [63:0] xw_result,
    output logic       xw_is_load,
    output logic [2:0] xw_funct3,
    output logic       xw_write_back
);
    import rv_core_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [5:0]      shamt;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] ex_result;

    // result leaving writeback this cycle, alu or load.
    function automatic logic [xlen-1:0] fwd(input logic [4:0] src, input logic [xlen-1:0] val);
        if (src == 5'd0) begin
            return val;
        end
        if (wb_en && wb_rd == src) begin
            return wb_value;
        end
        return val;
    endfunction

    always_comb begin
        op_a = fwd(dx_rs1, dx_op1);
        op_b = dx_imm_flag ? dx_op2 : fwd(dx_rs2, dx_op2);
    end

    assign shamt = op_b[5:0];

    always_comb begin
        case (dx_funct3)
            f3_add:  alu_out = (dx_funct7_alt && !dx_imm_flag) ? op_a - op_b : op_a + op_b;
            f3_sll:  alu_out = op_a << shamt;
            f3_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            f3_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < op_b};
            f3_xor:  alu_out = op_a ^ op_b;
            f3_srl:  alu_out = dx_funct7_alt ? $unsigned($signed(op_a) >>> shamt) : op_a >> shamt;
            f3_or:   alu_out = op_a | op_b;
            f3_and:  alu_out = op_a & op_b;
            default: alu_out = '0;
        endcase
    end

    assign ex_result = dx_is_load ? op_a + op_b : alu_out; // load address is rs1 + imm.

    always_ff @(posedge CLK or negedge reset) begin
        if (!reset) begin
            xw_valid      <= 1'b0;
            xw_is_load    <= 1'b0;
            xw_write_back <= 1'b0;
        end else begin
            xw_valid      <= dx_valid;
            xw_is_load    <= dx_is_load;
            xw_write_back <= dx_write_back;
        end
    end

    always_ff @(posedge CLK) begin
        xw_rd     <= dx_rd;
        xw_result <= ex_result;
        xw_funct3 <= dx_funct3;
    end

endmodule

`default_nettype wire

// ==== load_writeback.sv ====
`default_nettype none

module load_writeback (
    input  wire         xw_valid,
    input  wire [4:0]   xw_rd,
    input  wire [63:0]  xw_result,
    input  wire         xw_is_load,
    input  wire [2:0]   xw_funct3,
    input  wire         xw_write_back,
    input  wire [63:0]  mem_rdata,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [63:0] wb_value,
    output logic        retire_valid,
    output logic [4:0]  retire_rd,
    output logic [63:0] retire_value
);
    import rv_core_pkg::*;

    logic [xlen-1:0] lane;
    logic [xlen-1:0] load_value;

    assign lane = mem_rdata >> {xw_result[2:0], 3'b000}; // addressed byte to bit 0.

    always_comb begin
        case (xw_funct3)
            ld_b:    load_value = {{56{lane[7]}}, lane[7:0]};
            ld_h:    load_value = {{48{lane[15]}}, lane[15:0]};
            ld_w:    load_value = {{32{lane[31]}}, lane[31:0]};
            ld_d:    load_value = lane;
            ld_bu:   load_value = {56'd0, lane[7:0]};
            ld_hu:   load_value = {48'd0, lane[15:0]};
            ld_wu:   load_value = {32'd0, lane[31:0]};
            default: load_value = '0;
        endcase
    end

    assign wb_en    = xw_valid && xw_write_back;
    assign wb_rd    = xw_rd;
    assign wb_value = xw_is_load ? load_value : xw_result;

    // retire port mirrors the register write.
    assign retire_valid = wb_en;
    assign retire_rd    = wb_rd;
    assign retire_value = wb_value;

    always_comb begin
        a_no_x0_write : assert final (!(wb_en && wb_rd == 5'd0))
            else $error("writeback enabled for x0");
    end

endmodule

`default_nettype wire

// ==== rv_core_top.sv ====
`default_nettype none

module rv_core_top (
    input  wire         CLK,
    input  wire         reset,
    input  wire         stall,
    input  wire [31:0]  inst,
    output logic [63:0] inst_addr,
    input  wire [63:0]  mem_rdata,
    output logic [63:0] mem_addr,
    output logic        mem_rd_en,
    output logic        retire_valid,
    output logic [4:0]  retire_rd,
    output logic [63:0] retire_value
);
    import rv_core_pkg::*;

    logic            hold;
    logic            bubble;
    rv_inst_t        fd_inst;
    logic            fd_uses_rs1;
    logic            fd_uses_rs2;
    logic [4:0]      fd_rs1;
    logic [4:0]      fd_rs2;

    logic            dx_valid;
    logic [4:0]      dx_rd;
    logic [4:0]      dx_rs1;
    logic [4:0]      dx_rs2;
    logic [2:0]      dx_funct3;
    logic            dx_funct7_alt;
    logic [xlen-1:0] dx_op1;
    logic [xlen-1:0] dx_op2;
    logic            dx_imm_flag;
    logic            dx_is_load;
    logic            dx_write_back;

    logic            xw_valid;
    logic [4:0]      xw_rd;
    logic [xlen-1:0] xw_result;
    logic            xw_is_load;
    logic [2:0]      xw_funct3;
    logic            xw_write_back;

    logic            wb_en;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_value;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data memory port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign mem_addr  = {xw_result[63:3], 3'b000}; // doubleword aligned.
    assign mem_rd_en = xw_is_load;

    pc_counter u_pc (
        .CLK(CLK), .reset(reset), .hold(hold), .bubble(bubble),
        .inst(inst), .inst_addr(inst_addr), .fd_inst(fd_inst)
    );

    hazard_control u_hazard (
        .CLK(CLK), .reset(reset), .stall(stall),
        .fd_uses_rs1(fd_uses_rs1), .fd_uses_rs2(fd_uses_rs2),
        .fd_rs1(fd_rs1), .fd_rs2(fd_rs2),
        .dx_is_load(dx_is_load), .dx_rd(dx_rd),
        .hold(hold), .bubble(bubble)
    );

    inst_decode u_decode (
        .CLK(CLK), .reset(reset), .fd_inst(fd_inst), .bubble(bubble),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_value(wb_value),
        .fd_uses_rs1(fd_uses_rs1), .fd_uses_rs2(fd_uses_rs2),
        .fd_rs1(fd_rs1), .fd_rs2(fd_rs2),
        .dx_valid(dx_valid), .dx_rd(dx_rd), .dx_rs1(dx_rs1), .dx_rs2(dx_rs2),
        .dx_funct3(dx_funct3), .dx_funct7_alt(dx_funct7_alt),
        .dx_op1(dx_op1), .dx_op2(dx_op2), .dx_imm_flag(dx_imm_flag),
        .dx_is_load(dx_is_load), .dx_write_back(dx_write_back)
    );

    alu_execute u_execute (
        .CLK(CLK), .reset(reset),
        .dx_valid(dx_valid), .dx_rd(dx_rd), .dx_rs1(dx_rs1), .dx_rs2(dx_rs2),
        .dx_funct3(dx_funct3), .dx_funct7_alt(dx_funct7_alt),
        .dx_op1(dx_op1), .dx_op2(dx_op2), .dx_imm_flag(dx_imm_flag),
        .dx_is_load(dx_is_load), .dx_write_back(dx_write_back),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_value(wb_value),
        .xw_valid(xw_valid), .xw_rd(xw_rd), .xw_result(xw_result),
        .xw_is_load(xw_is_load), .xw_funct3(xw_funct3), .xw_write_back(xw_write_back)
    );

    load_writeback u_writeback (
        .xw_valid(xw_valid), .xw_rd(xw_rd), .xw_result(xw_result),
        .xw_is_load(xw_is_load), .xw_funct3(xw_funct3), .xw_write_back(xw_write_back),
        .mem_rdata(mem_rdata),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_value(wb_value),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
    );

endmodule

`default_nettype wire

// ==== core_checker.sv ====
`default_nettype none

module core_checker (
    input wire        CLK,
    input wire        reset,
    input wire        retire_valid,
    input wire [4:0]  retire_rd,
    input wire [63:0] retire_value,
    input wire        mem_rd_en,
    input wire [63:0] mem_addr
);
    import rv_core_pkg::*;

    logic [31:0] prog_mem [256];
    logic [63:0] data_mem [256];
    logic [63:0] regs [32];
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_val [$];
    logic        exp_load [$];
    logic [63:0] exp_addr [$];
    logic [4:0]  want_rd;
    logic [63:0] want_val;
    logic        want_load;
    logic [63:0] want_addr;
    int          errors = 0;
    int          retired = 0;
    int          expected_total = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ISA reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt_op,
                                            input logic [63:0] a, input logic [63:0] b);
        case (f3)
            f3_add:  return alt_op ? a - b : a + b;
            f3_sll:  return a << b[5:0];
            f3_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            f3_sltu: return (a < b) ? 64'd1 : 64'd0;
            f3_xor:  return a ^ b;
            f3_srl: begin
                if (alt_op) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
            f3_or:   return a | b;
            default: return a & b;
        endcase
    endfunction

    // gathers the addressed bytes one by one, then extends.
    function automatic logic [63:0] load_ref(input logic [2:0] f3, input logic [63:0] addr);
        int          size;
        logic [63:0] dw;
        logic [63:0] val;
        size = 1 << f3[1:0];
        dw   = data_mem[addr[10:3]];
        val  = '0;
        for (int k = 0; k < size; k++) begin
            val[8*k +: 8] = dw[8*(addr[2:0] + k) +: 8];
        end
        if (!f3[2] && size < 8 && val[8*size-1]) begin
            val = val | (~64'd0 << (8*size)); // signed forms.
        end
        return val;
    endfunction

    task automatic load_image(input int idx, input logic [31:0] word, input logic [63:0] dword);
        prog_mem[idx] = word;
        data_mem[idx] = dword;
    endtask

    task automatic run_model(input int n);
        logic [31:0] w;
        logic [4:0]  rd;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm;
        logic [63:0] ea;
        logic [63:0] res;
        logic        is_ld;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < n; i++) begin
            w     = prog_mem[i];
            rd    = w[11:7];
            a     = regs[w[19:15]];
            b     = regs[w[24:20]];
            imm   = {{52{w[31]}}, w[31:20]};
            ea    = a + imm;
            is_ld = w[6:0] == opc_load;
            res   = '0;
            case (w[6:0])
                opc_op:     res = alu_ref(w[14:12], w[31:25] == f7_alt, a, b);
                opc_op_imm: res = alu_ref(w[14:12],
                                          w[14:12] == f3_srl && w[31:26] == 6'b010000, a, imm);
                opc_load:   res = load_ref(w[14:12], ea);
                default:    rd = 5'd0; // no writeback.
            endcase
            if (rd != 5'd0) begin
                regs[rd] = res;
                exp_rd.push_back(rd);
                exp_val.push_back(res);
                exp_load.push_back(is_ld);
                exp_addr.push_back(ea & ~64'd7);
            end
        end
        expected_total = exp_rd.size();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // retire compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge CLK) begin
        if (reset && retire_valid) begin
            retired++;
            if (exp_rd.size() == 0) begin
                $display("unexpected retirement at %0t: rd %0d retired after the whole program",
                         $time, retire_rd);
                errors++;
            end else begin
                want_rd   = exp_rd.pop_front();
                want_val  = exp_val.pop_front();
                want_load = exp_load.pop_front();
                want_addr = exp_addr.pop_front();
                if (retire_rd !== want_rd) begin
                    $display("Fail time=%0t retire_rd expected=%0d actual=%0d",
                             $time, want_rd, retire_rd);
                    errors++;
                end
                if (retire_value !== want_val) begin
                    $display("Fail time=%0t retire_value expected=%h actual=%h",
                             $time, want_val, retire_value);
                    errors++;
                end
                if (mem_rd_en !== want_load) begin
                    $display("Fail time=%0t mem_rd_en expected=%0b actual=%0b",
                             $time, want_load, mem_rd_en);
                    errors++;
                end
                if (want_load && mem_addr !== want_addr) begin
                    $display("Fail time=%0t mem_addr expected=%h actual=%h",
                             $time, want_addr, mem_addr);
                    errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    logic        CLK;
    logic        reset;
    logic        stall;
    logic [31:0] inst;
    logic [63:0] inst_addr;
    logic [63:0] mem_rdata;
    logic [63:0] mem_addr;
    logic        mem_rd_en;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [63:0] retire_value;

    logic [31:0] imem [256];
    logic [63:0] dmem [256];
    int          cycles;
    int          timeouts;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign inst      = (inst_addr < 64'd1024) ? imem[inst_addr[9:2]] : inst_nop;
    assign mem_rdata = dmem[mem_addr[10:3]];

    // mostly x0..x5 so that hazards are frequent, x31 stays the load base.
    function automatic logic [4:0] pick_reg();
        logic [2:0] r;
        r = 3'($urandom % 8);
        if (r < 3'd6) begin
            return {2'b00, r};
        end
        return 5'(6 + $urandom % 25);
    endfunction

    function automatic logic [31:0] random_inst();
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [5:0]  shamt;
        logic        alt;
        logic [11:0] imm;
        f3    = 3'($urandom % 8);
        rd    = pick_reg();
        rs1   = pick_reg();
        shamt = 6'($urandom % 64);
        alt   = ($urandom % 2) == 1;
        case ($urandom % 3)
            0: begin
                alt = alt && (f3 == f3_add || f3 == f3_srl);
                return {alt ? f7_alt : 7'd0, pick_reg(), rs1, f3, rd, opc_op};
            end
            1: begin
                if (f3 == f3_sll || f3 == f3_srl) begin
                    imm = {(alt && f3 == f3_srl) ? 6'b010000 : 6'b000000, shamt};
                end else begin
                    imm = 12'($urandom % 4096);
                end
                return {imm, rs1, f3, rd, opc_op_imm};
            end
            default: begin
                f3  = 3'($urandom % 7);
                imm = 12'(($urandom % 1792) & ~((32'd1 << f3[1:0]) - 1)); // aligned to width.
                return {imm, ($urandom % 2) ? 5'd31 : 5'd0, f3, rd, opc_load};
            end
        endcase
    endfunction

    rv_core_top UUT (
        .CLK(CLK), .reset(reset), .stall(stall),
        .inst(inst), .inst_addr(inst_addr),
        .mem_rdata(mem_rdata), .mem_addr(mem_addr), .mem_rd_en(mem_rd_en),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
    );

    core_checker chk (
        .CLK(CLK), .reset(reset), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_value(retire_value),
        .mem_rd_en(mem_rd_en), .mem_addr(mem_addr)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        void'($urandom(32'h0ba9260a));
        reset    = 1'b0;
        stall    = 1'b0;
        timeouts = 0;
        imem[0]  = {12'd256, 5'd0, f3_add, 5'd31, opc_op_imm}; // addi x31, x0, 256.
        for (int i = 1; i < 256; i++) begin
            if (i < 200) begin
                imem[i] = random_inst();
            end else begin
                imem[i] = inst_nop;
            end
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {$urandom, $urandom};
            chk.load_image(i, imem[i], dmem[i]);
        end
        chk.run_model(200);

        repeat (16) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b1;

        cycles = 0;
        while (chk.retired < chk.expected_total && cycles < 5000) begin
            @(negedge CLK);
            stall = ($urandom % 5) == 0;
            cycles++;
            @(posedge CLK);
        end
        @(negedge CLK);
        stall = 1'b0;
        repeat (10) @(negedge CLK); // catch any extra retirement.

        if (chk.retired < chk.expected_total) begin
            $display("timeout: only %0d of %0d instructions retired after %0d cycles",
                     chk.retired, chk.expected_total, cycles);
            timeouts++;
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d instructions retired",
                 chk.errors, timeouts, chk.retired);
        if (chk.errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
rv_core_pkg.sv
pc_counter.sv
hazard_control.sv
inst_decode.sv
alu_execute.sv
load_writeback.sv
rv_core_top.sv
core_checker.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - pc_counter.sv
  - hazard_control.sv
  - inst_decode.sv
  - alu_execute.sv
  - load_writeback.sv
  - rv_core_top.sv
  - target: test
    files:
      - core_checker.sv
      - tb_rv_core.sv
